// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rvPkg.sv
      - hdl/coreIf.sv
      - hdl/pipeControl.sv
      - hdl/fetchDecode.sv
      - hdl/executeStage.sv
      - hdl/memWriteback.sv
      - hdl/rvCore.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tb/tb_rvCore.sv

// ==== hdl/coreIf.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

// decoded control between the control unit and the datapath
interface ctrlIf;
  import rvPkg::*;

  instrWord  instrD;
  logic      zeroE;
  immSrcT    immSrcD;
  logic      aluSrcE;
  aluCtrlT   aluCtrlE;
  logic      pcSrcE;
  resultSrcT resultSrcW;
  logic      regWriteW;
  // memory-stage write strobe, taken straight to the top level
  logic      memWriteM;

  modport ctrl (
    input  instrD, zeroE,
    output immSrcD, aluSrcE, aluCtrlE, pcSrcE, resultSrcW, regWriteW, memWriteM
  );
  modport dp (
    output instrD, zeroE,
    input  immSrcD, aluSrcE, aluCtrlE, pcSrcE, resultSrcW, regWriteW
  );
endinterface

// register indices in, stall, flush and forward selects out
interface hazardIf;
  import rvPkg::*;

  logic [`REG_ADDR_W-1:0] rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
  logic                   stallFD, flushD, flushE;
  fwdSelT                 fwdA, fwdB;

  modport ctrl (
    input  rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
    output stallFD, flushD, flushE, fwdA, fwdB
  );
  // rdM and rdW come from the memory/writeback registers at the top level
  modport dp (
    output rs1D, rs2D, rs1E, rs2E, rdE,
    input  rdM, rdW, stallFD, flushD, flushE, fwdA, fwdB
  );
endinterface

// ==== hdl/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and address width
`define XLEN 32

// register index width, 32 architectural registers
`define REG_ADDR_W 5

// sequential fetch step in bytes
`define PC_STEP 32'd4
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module executeStage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`XLEN-1:0]       pcD,
  input  logic [`XLEN-1:0]       pcPlus4D,
  input  logic [`XLEN-1:0]       rd1D,
  input  logic [`XLEN-1:0]       rd2D,
  input  logic [`XLEN-1:0]       immExtD,
  input  logic [`REG_ADDR_W-1:0] rdD,
  input  logic [`XLEN-1:0]       aluResultM,
  input  logic [`XLEN-1:0]       resultW,
  output logic [`XLEN-1:0]       aluResultE,
  output logic [`XLEN-1:0]       writeDataE,
  output logic [`XLEN-1:0]       pcPlus4E,
  output logic [`XLEN-1:0]       pcTargetE,
  output logic [`REG_ADDR_W-1:0] rdE,
  ctrlIf.dp                      ctrl,
  hazardIf.dp                    hz
);
  import rvPkg::*;

  logic [`XLEN-1:0] pcE, rd1E, rd2E, immExtE;
  logic [`XLEN-1:0] srcAE, srcBE;

  // indices feed the hazard unit, so they need a known value after reset
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset || hz.flushE)
    begin
      hz.rs1E <= '0;
      hz.rs2E <= '0;
      rdE     <= '0;
    end
    else
    begin
      hz.rs1E <= hz.rs1D;
      hz.rs2E <= hz.rs2D;
      rdE     <= rdD;
    end
  end

  always_ff @(posedge clk)
  begin
    if (hz.flushE)
    begin
      pcE      <= '0;
      pcPlus4E <= '0;
      rd1E     <= '0;
      rd2E     <= '0;
      immExtE  <= '0;
    end
    else
    begin
      pcE      <= pcD;
      pcPlus4E <= pcPlus4D;
      rd1E     <= rd1D;
      rd2E     <= rd2D;
      immExtE  <= immExtD;
    end
  end

  assign hz.rdE = rdE;

  // forwarding muxes
  always_comb
  begin
    case (hz.fwdA)
      fwdWb:   srcAE = resultW;
      fwdMem:  srcAE = aluResultM;
      default: srcAE = rd1E;
    endcase
    case (hz.fwdB)
      fwdWb:   writeDataE = resultW;
      fwdMem:  writeDataE = aluResultM;
      default: writeDataE = rd2E;
    endcase
  end

  assign srcBE = ctrl.aluSrcE ? immExtE : writeDataE;

  always_comb
  begin
    case (ctrl.aluCtrlE)
      aluSub:  aluResultE = srcAE - srcBE;
      aluAnd:  aluResultE = srcAE & srcBE;
      aluOr:   aluResultE = srcAE | srcBE;
      // signed compare
      aluSlt:  aluResultE = {{(`XLEN-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
      default: aluResultE = srcAE + srcBE;
    endcase
  end

  // beq relies on sub giving zero
  assign ctrl.zeroE = (aluResultE == '0);

  // branch and jal target
  assign pcTargetE = pcE + immExtE;

endmodule

// ==== hdl/fetchDecode.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module fetchDecode (
  input  logic                   clk,
  input  logic                   reset,
  input  rvPkg::instrWord        instr,
  input  logic [`XLEN-1:0]       pcTargetE,
  input  logic [`XLEN-1:0]       resultW,
  output logic [`XLEN-1:0]       pc,
  output logic [`XLEN-1:0]       pcD,
  output logic [`XLEN-1:0]       pcPlus4D,
  output logic [`XLEN-1:0]       rd1D,
  output logic [`XLEN-1:0]       rd2D,
  output logic [`XLEN-1:0]       immExtD,
  output logic [`REG_ADDR_W-1:0] rdD,
  ctrlIf.dp                      ctrl,
  hazardIf.dp                    hz
);
  import rvPkg::*;

  logic [`XLEN-1:0] pcPlus4F;
  // x0 has no storage
  logic [`XLEN-1:0] regs [1:(2**`REG_ADDR_W)-1];

  // register read with write-through from writeback
  function automatic logic [`XLEN-1:0] readReg(input logic [`REG_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] value;
    if (addr == '0)
      value = '0;
    else if (ctrl.regWriteW && addr == hz.rdW)
      value = resultW;
    else
      value = regs[addr];
    return value;
  endfunction

  assign pcPlus4F = pc + `PC_STEP;

  // redirect wins, a stall holds pc
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= `RESET_PC;
    else if (ctrl.pcSrcE)
      pc <= pcTargetE;
    else if (!hz.stallFD)
      pc <= pcPlus4F;
  end

  // fetch/decode register, nop after reset or flush
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ctrl.instrD <= `NOP_INSTR;
    else if (hz.flushD)
      ctrl.instrD <= `NOP_INSTR;
    else if (!hz.stallFD)
      ctrl.instrD <= instr;
  end

  // pc copies only matter once a real instruction follows them
  always_ff @(posedge clk)
  begin
    if (!hz.stallFD)
    begin
      pcD      <= pc;
      pcPlus4D <= pcPlus4F;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ctrl.regWriteW && hz.rdW != '0)
      regs[hz.rdW] <= resultW;
  end

  assign hz.rs1D = ctrl.instrD.r.rs1;
  assign hz.rs2D = ctrl.instrD.r.rs2;
  assign rdD     = ctrl.instrD.r.rd;

  always_comb
  begin
    rd1D = readReg(hz.rs1D);
    rd2D = readReg(hz.rs2D);
  end

  // sign extension per format
  always_comb
  begin
    case (ctrl.immSrcD)
      immI: immExtD = {{(`XLEN-12){ctrl.instrD.i.imm[11]}}, ctrl.instrD.i.imm};
      immS: immExtD = {{(`XLEN-12){ctrl.instrD.s.imm11_5[6]}},
                       ctrl.instrD.s.imm11_5, ctrl.instrD.s.imm4_0};
      immB: immExtD = {{(`XLEN-12){ctrl.instrD.b.imm12}}, ctrl.instrD.b.imm11,
                       ctrl.instrD.b.imm10_5, ctrl.instrD.b.imm4_1, 1'b0};
      immJ: immExtD = {{(`XLEN-20){ctrl.instrD.j.imm20}}, ctrl.instrD.j.imm19_12,
                       ctrl.instrD.j.imm11, ctrl.instrD.j.imm10_1, 1'b0};
      default: immExtD = '0;
    endcase
  end

endmodule

// ==== hdl/memWriteback.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module memWriteback (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`XLEN-1:0]       aluResultE,
  input  logic [`XLEN-1:0]       writeDataE,
  input  logic [`XLEN-1:0]       pcPlus4E,
  input  logic [`REG_ADDR_W-1:0] rdE,
  input  logic [`XLEN-1:0]       readData,
  output logic [`XLEN-1:0]       dataAdr,
  output logic [`XLEN-1:0]       writeData,
  output logic [`XLEN-1:0]       resultW,
  output logic [`REG_ADDR_W-1:0] rdM,
  output logic [`REG_ADDR_W-1:0] rdW,
  ctrlIf.dp                      ctrl
);
  import rvPkg::*;

  logic [`XLEN-1:0] pcPlus4M;
  logic [`XLEN-1:0] aluResultW, readDataW, pcPlus4W;

  // memory stage presents address and store data directly
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rdM <= '0;
      rdW <= '0;
    end
    else
    begin
      rdM <= rdE;
      rdW <= rdM;
    end
  end

  always_ff @(posedge clk)
  begin
    dataAdr    <= aluResultE;
    writeData  <= writeDataE;
    pcPlus4M   <= pcPlus4E;
    aluResultW <= dataAdr;
    readDataW  <= readData;
    pcPlus4W   <= pcPlus4M;
  end

  // writeback result select
  always_comb
  begin
    case (ctrl.resultSrcW)
      resMem:  resultW = readDataW;
      resPc4:  resultW = pcPlus4W;
      default: resultW = aluResultW;
    endcase
  end

endmodule

// ==== hdl/pipeControl.sv ====
`timescale 1ns/1ps

module pipeControl (
  input  logic clk,
  input  logic reset,
  ctrlIf.ctrl  ctrl,
  hazardIf.ctrl hz
);
  import rvPkg::*;

  // decode stage controls
  logic      regWriteD, memWriteD, aluSrcD, branchD, jumpD;
  resultSrcT resultSrcD;
  logic [1:0] aluOpD;
  aluCtrlT   aluCtrlD;
  logic      rTypeSub;

  // execute and later stage copies
  logic      regWriteE, memWriteE, branchE, jumpE;
  resultSrcT resultSrcE, resultSrcM;
  logic      regWriteM;
  logic      lwStall;

  // select the youngest producer of a source register
  function automatic fwdSelT pickFwd(input logic [4:0] rsE);
    fwdSelT sel;
    sel = fwdReg;
    if (rsE != '0)
    begin
      if (regWriteM && rsE == hz.rdM)
        sel = fwdMem;
      else if (ctrl.regWriteW && rsE == hz.rdW)
        sel = fwdWb;
    end
    return sel;
  endfunction

  // main decode
  // aluOp 00 add, 01 sub for beq, 10 from funct fields
  always_comb
  begin
    regWriteD    = 1'b0;
    memWriteD    = 1'b0;
    aluSrcD      = 1'b0;
    branchD      = 1'b0;
    jumpD        = 1'b0;
    resultSrcD   = resAlu;
    aluOpD       = 2'b00;
    ctrl.immSrcD = immI;
    case (ctrl.instrD.r.opcode)
      opLoad:
      begin
        regWriteD  = 1'b1;
        aluSrcD    = 1'b1;
        resultSrcD = resMem;
      end
      opStore:
      begin
        memWriteD    = 1'b1;
        aluSrcD      = 1'b1;
        ctrl.immSrcD = immS;
      end
      opOp:
      begin
        regWriteD = 1'b1;
        aluOpD    = 2'b10;
      end
      opOpImm:
      begin
        regWriteD = 1'b1;
        aluSrcD   = 1'b1;
        aluOpD    = 2'b10;
      end
      opBranch:
      begin
        branchD      = 1'b1;
        aluOpD       = 2'b01;
        ctrl.immSrcD = immB;
      end
      opJal:
      begin
        regWriteD    = 1'b1;
        jumpD        = 1'b1;
        resultSrcD   = resPc4;
        ctrl.immSrcD = immJ;
      end
      // unknown opcodes behave as a bubble
      default:
      begin
        regWriteD = 1'b0;
      end
    endcase
  end

  // alu decode, sub only for the register form
  assign rTypeSub = ctrl.instrD.r.funct7[5] && (ctrl.instrD.r.opcode == opOp);

  always_comb
  begin
    aluCtrlD = aluAdd;
    if (aluOpD == 2'b01)
      aluCtrlD = aluSub;
    else if (aluOpD == 2'b10)
    begin
      case (ctrl.instrD.r.funct3)
        f3AddSub: aluCtrlD = rTypeSub ? aluSub : aluAdd;
        f3Slt:    aluCtrlD = aluSlt;
        f3Or:     aluCtrlD = aluOr;
        f3And:    aluCtrlD = aluAnd;
        default:  aluCtrlD = aluAdd;
      endcase
    end
  end

  // decode to execute, bubble on flush
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset || hz.flushE)
    begin
      regWriteE     <= 1'b0;
      memWriteE     <= 1'b0;
      branchE       <= 1'b0;
      jumpE         <= 1'b0;
      resultSrcE    <= resAlu;
      ctrl.aluSrcE  <= 1'b0;
      ctrl.aluCtrlE <= aluAdd;
    end
    else
    begin
      regWriteE     <= regWriteD;
      memWriteE     <= memWriteD;
      branchE       <= branchD;
      jumpE         <= jumpD;
      resultSrcE    <= resultSrcD;
      ctrl.aluSrcE  <= aluSrcD;
      ctrl.aluCtrlE <= aluCtrlD;
    end
  end

  // execute to memory to writeback
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      regWriteM       <= 1'b0;
      ctrl.memWriteM  <= 1'b0;
      resultSrcM      <= resAlu;
      ctrl.regWriteW  <= 1'b0;
      ctrl.resultSrcW <= resAlu;
    end
    else
    begin
      regWriteM       <= regWriteE;
      ctrl.memWriteM  <= memWriteE;
      resultSrcM      <= resultSrcE;
      ctrl.regWriteW  <= regWriteM;
      ctrl.resultSrcW <= resultSrcM;
    end
  end

  // branch resolves in execute
  assign ctrl.pcSrcE = (branchE && ctrl.zeroE) || jumpE;

  assign hz.fwdA = pickFwd(hz.rs1E);
  assign hz.fwdB = pickFwd(hz.rs2E);

  // load in execute feeding the instruction in decode
  assign lwStall = (resultSrcE == resMem) && (hz.rdE != '0) &&
                   ((hz.rdE == hz.rs1D) || (hz.rdE == hz.rs2D));

  assign hz.stallFD = lwStall;
  assign hz.flushD  = ctrl.pcSrcE;
  assign hz.flushE  = lwStall || ctrl.pcSrcE;

endmodule

// ==== hdl/rvCore.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module rvCore (
  input  logic             clk,
  input  logic             reset,
  input  logic [`XLEN-1:0] instr,
  input  logic [`XLEN-1:0] readData,
  output logic [`XLEN-1:0] pc,
  output logic             memWrite,
  output logic [`XLEN-1:0] dataAdr,
  output logic [`XLEN-1:0] writeData
);

  logic [`XLEN-1:0]       pcD, pcPlus4D, rd1D, rd2D, immExtD;
  logic [`XLEN-1:0]       aluResultE, writeDataE, pcPlus4E, pcTargetE;
  logic [`XLEN-1:0]       resultW;
  logic [`REG_ADDR_W-1:0] rdD, rdE;

  ctrlIf   ctrlBus ();
  hazardIf hzBus ();

  pipeControl uControl (
    .clk (clk), .reset (reset), .ctrl (ctrlBus.ctrl), .hz (hzBus.ctrl)
  );

  fetchDecode uFetch (
    .clk (clk), .reset (reset), .instr (instr), .pcTargetE (pcTargetE),
    .resultW (resultW), .pc (pc), .pcD (pcD), .pcPlus4D (pcPlus4D),
    .rd1D (rd1D), .rd2D (rd2D), .immExtD (immExtD), .rdD (rdD),
    .ctrl (ctrlBus.dp), .hz (hzBus.dp)
  );

  executeStage uExecute (
    .clk (clk), .reset (reset), .pcD (pcD), .pcPlus4D (pcPlus4D),
    .rd1D (rd1D), .rd2D (rd2D), .immExtD (immExtD), .rdD (rdD),
    .aluResultM (dataAdr), .resultW (resultW), .aluResultE (aluResultE),
    .writeDataE (writeDataE), .pcPlus4E (pcPlus4E), .pcTargetE (pcTargetE),
    .rdE (rdE), .ctrl (ctrlBus.dp), .hz (hzBus.dp)
  );

  // memory-stage address doubles as the forwarded alu result
  memWriteback uMemWb (
    .clk (clk), .reset (reset), .aluResultE (aluResultE), .writeDataE (writeDataE),
    .pcPlus4E (pcPlus4E), .rdE (rdE), .readData (readData), .dataAdr (dataAdr),
    .writeData (writeData), .resultW (resultW), .rdM (hzBus.rdM), .rdW (hzBus.rdW),
    .ctrl (ctrlBus.dp)
  );

  assign memWrite = ctrlBus.memWriteM;

endmodule

// ==== hdl/rvPkg.sv ====
package rvPkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opOp     = 7'b0110011,
    opOpImm  = 7'b0010011,
    opBranch = 7'b1100011,
    opJal    = 7'b1101111
  } opcodeT;

  // funct3 codes for alu instructions
  typedef enum logic [2:0] {
    f3AddSub = 3'b000,
    f3Slt    = 3'b010,
    f3Or     = 3'b110,
    f3And    = 3'b111
  } aluFunct3T;

  typedef enum logic [2:0] {
    aluAdd = 3'b000,
    aluSub = 3'b001,
    aluAnd = 3'b010,
    aluOr  = 3'b011,
    aluSlt = 3'b101
  } aluCtrlT;

  typedef enum logic [1:0] {immI, immS, immB, immJ} immSrcT;

  // writeback source
  typedef enum logic [1:0] {resAlu, resMem, resPc4} resultSrcT;

  // execute operand source
  typedef enum logic [1:0] {fwdReg, fwdWb, fwdMem} fwdSelT;

  // one fetched word, seen through every instruction format
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcodeT     opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcodeT      opcode;
    } i;
    struct packed {
      logic [6:0] imm11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm4_0;
      opcodeT     opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      opcodeT     opcode;
    } b;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      opcodeT     opcode;
    } j;
  } instrWord;

endpackage

// ==== list.f ====
+incdir+hdl
hdl/rvPkg.sv
hdl/coreIf.sv
hdl/pipeControl.sv
hdl/fetchDecode.sv
hdl/executeStage.sv
hdl/memWriteback.sv
hdl/rvCore.sv
tb/tb_rvCore.sv

// ==== tb/program_stimulus.txt ====
// columns: kind address data, all hex
// kind 0 program word, kind 1 initial data word, kind 2 expected store in order
0 00000000 00600093  // addi x1, x0, 6
0 00000004 FF300113  // addi x2, x0, -13
0 00000008 002081B3  // add  x3, x1, x2
0 0000000C 04302023  // sw   x3, 0x40(x0)
0 00000010 40308233  // sub  x4, x1, x3
0 00000014 04402223  // sw   x4, 0x44(x0)
0 00000018 002272B3  // and  x5, x4, x2
0 0000001C 0012E333  // or   x6, x5, x1
0 00000020 04502423  // sw   x5, 0x48(x0)
0 00000024 04602623  // sw   x6, 0x4c(x0)
0 00000028 006123B3  // slt  x7, x2, x6
0 0000002C 0303E413  // ori  x8, x7, 0x30
0 00000030 FF047493  // andi x9, x8, -16
0 00000034 04802823  // sw   x8, 0x50(x0)
0 00000038 0314A513  // slti x10, x9, 0x31
0 0000003C 04902A23  // sw   x9, 0x54(x0)
0 00000040 04A02C23  // sw   x10, 0x58(x0)
0 00000044 08002583  // lw   x11, 0x80(x0)
0 00000048 01058613  // addi x12, x11, 0x10
0 0000004C 04C02E23  // sw   x12, 0x5c(x0)
0 00000050 00208463  // beq  x1, x2, +8 not taken
0 00000054 06102023  // sw   x1, 0x60(x0)
0 00000058 00A38663  // beq  x7, x10, +12 taken
0 0000005C 06202223  // sw   x2, 0x64(x0) skipped
0 00000060 06302423  // sw   x3, 0x68(x0) skipped
0 00000064 008006EF  // jal  x13, +8
0 00000068 06202623  // sw   x2, 0x6c(x0) skipped
0 0000006C 06D02823  // sw   x13, 0x70(x0)
0 00000070 06300013  // addi x0, x0, 99
0 00000074 06002A23  // sw   x0, 0x74(x0)
0 00000078 0000006F  // jal  x0, 0
0 0000007C 00000013  // nop
0 00000080 00000013  // nop
1 00000080 12345678
2 00000040 FFFFFFF9
2 00000044 0000000D
2 00000048 00000001
2 0000004C 00000007
2 00000050 00000031
2 00000054 00000030
2 00000058 00000001
2 0000005C 12345688
2 00000060 00000006
2 00000070 00000068
2 00000074 00000000

// ==== tb/tb_rvCore.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_rvCore;

  // stimulus file rows hold kind, address and data
  localparam int MaxRows  = 128;
  localparam int MemWords = 64;

  logic                   clk;
  logic                   reset;
  logic [`XLEN-1:0]       instr;
  logic [`XLEN-1:0]       readData;
  logic [`XLEN-1:0]       pc;
  logic                   memWrite;
  logic [`XLEN-1:0]       dataAdr;
  logic [`XLEN-1:0]       writeData;

  logic [31:0]            stim [0:3*MaxRows-1];
  logic [`XLEN-1:0]       imem [0:MemWords-1];
  logic [`XLEN-1:0]       dmem [0:MemWords-1];
  logic [`XLEN-1:0]       expAdr [$];
  logic [`XLEN-1:0]       expData [$];

  int progLen, storesSeen, valueErrors, otherErrors, cycles, cycleLimit;
  bit running;

  rvCore u_dut (
    .clk (clk), .reset (reset), .instr (instr), .readData (readData),
    .pc (pc), .memWrite (memWrite), .dataAdr (dataAdr), .writeData (writeData)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // 64-word memories indexed by byte address bits 7:2
  assign instr    = imem[pc[7:2]];
  assign readData = dmem[dataAdr[7:2]];

  always @(posedge clk)
  begin
    if (memWrite)
      dmem[dataAdr[7:2]] <= writeData;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    assert (actual === expected)
    else
    begin
      valueErrors++;
      $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // sort file rows into program, initial data and expected stores
  task automatic loadStimulus();
    int row;
    for (row = 0; row < 3 * MaxRows; row++)
      stim[row] = '1;
    // background data differs at every byte address
    for (row = 0; row < MemWords; row++)
      dmem[row] = 32'hDA7A_0000 ^ (row << 2);
    $readmemh("tb/program_stimulus.txt", stim);
    progLen = 0;
    for (row = 0; row < MaxRows && stim[3 * row] != '1; row++)
    begin
      if (stim[3 * row] == 0)
      begin
        imem[stim[3 * row + 1][7:2]] = stim[3 * row + 2];
        progLen++;
      end
      else if (stim[3 * row] == 1)
        dmem[stim[3 * row + 1][7:2]] = stim[3 * row + 2];
      else
      begin
        expAdr.push_back(stim[3 * row + 1]);
        expData.push_back(stim[3 * row + 2]);
      end
    end
  endtask

  // every store matched in order against the next expected one
  always @(negedge clk)
  begin
    if (running && memWrite)
    begin
      assert (storesSeen < expAdr.size())
      else
      begin
        otherErrors++;
        $display("unexpected extra store to address %h at %0t ns", dataAdr, $time);
      end
      if (storesSeen < expAdr.size())
      begin
        checkValue("dataAdr", dataAdr, expAdr[storesSeen]);
        checkValue("writeData", writeData, expData[storesSeen]);
        storesSeen++;
      end
    end
  end

  initial
  begin
    reset       = 1'b1;
    running     = 1'b0;
    storesSeen  = 0;
    valueErrors = 0;
    otherErrors = 0;
    cycles      = 0;
    loadStimulus();
    cycleLimit = 4 * progLen + 20;
    assert (expAdr.size() > 0)
    else
    begin
      otherErrors++;
      $display("stimulus file holds no expected stores");
    end
    // pc parked and no store across three reset edges
    @(posedge clk);
    repeat (2)
    begin
      @(negedge clk);
      checkValue("pc", pc, `RESET_PC);
      checkValue("memWrite", memWrite, 1'b0);
      @(posedge clk);
    end
    reset   <= 1'b0;
    running = 1'b1;
    // first cycle out of reset and two sequential steps
    @(negedge clk);
    checkValue("pc", pc, `RESET_PC);
    checkValue("memWrite", memWrite, 1'b0);
    @(negedge clk);
    checkValue("pc", pc, `RESET_PC + `PC_STEP);
    @(negedge clk);
    checkValue("pc", pc, `RESET_PC + 2 * `PC_STEP);
    while (storesSeen < expAdr.size() && cycles < cycleLimit)
    begin
      @(posedge clk);
      cycles++;
    end
    // younger instructions in fetch, decode and execute reach memory within three edges
    if (storesSeen == expAdr.size())
      repeat (3) @(posedge clk);
    running = 1'b0;
    assert (storesSeen == expAdr.size())
    else
    begin
      otherErrors++;
      $display("timeout after %0d cycles, %0d of %0d stores never came",
               cycles, expAdr.size() - storesSeen, expAdr.size());
    end
    $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule
